//--- dv/tb_clk_gen.sv
module tb_clk_gen (
	output logic clk_o
);

	// Period of 8 time units
	localparam int unsigned HALF_PERIOD = 4;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD clk_o = ~clk_o;
		end
	end

endmodule

//--- dv/tb_hart_mem_subsys.sv
`include "hart_mem_defines.svh"

module tb_hart_mem_subsys;

	localparam int unsigned MEM_WORDS = 1 << `HM_MEM_WORDS_LOG2;
	localparam int unsigned HALF_WORDS = MEM_WORDS / 2;
	localparam int unsigned N_WR = 48;
	localparam int unsigned N_EXTRA = 16;
	localparam int unsigned N_CC = 100;
	// Fill, writes, read back, fetches, both ports together, pause
	localparam int unsigned N_TXN = MEM_WORDS + N_WR + 2 * (N_WR + N_EXTRA) + 2 * N_CC + 4;
	localparam int unsigned TIMEOUT_CYCLES = N_TXN * 20 + 10;

	logic                clk;
	logic                rst_n;

	logic                inst_req;
	hart_mem_pkg::addr_t inst_addr;
	logic                inst_gnt;
	logic                inst_rvalid;
	hart_mem_pkg::data_t inst_rdata;

	logic                data_req;
	hart_mem_pkg::addr_t data_addr;
	logic                data_we;
	hart_mem_pkg::strb_t data_be;
	hart_mem_pkg::data_t data_wdata;
	logic                data_gnt;
	logic                data_rvalid;
	hart_mem_pkg::data_t data_rdata;

	logic                pause_req;
	logic                pause_ack;

	// Word index behind the address on each port
	hart_mem_pkg::word_idx_t inst_idx;
	hart_mem_pkg::word_idx_t data_idx;

	hart_mem_pkg::data_t     model_mem [MEM_WORDS];
	hart_mem_pkg::data_t     inst_exp_q [$];
	hart_mem_pkg::data_t     data_exp_q [$];
	bit                      data_chk_q [$];
	hart_mem_pkg::word_idx_t wr_idx [N_WR];

	tb_clk_gen u_clk (
		.clk_o (clk)
	);

	hart_mem_subsys dut (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.inst_req_i    (inst_req),
		.inst_addr_i   (inst_addr),
		.inst_gnt_o    (inst_gnt),
		.inst_rvalid_o (inst_rvalid),
		.inst_rdata_o  (inst_rdata),
		.data_req_i    (data_req),
		.data_addr_i   (data_addr),
		.data_we_i     (data_we),
		.data_be_i     (data_be),
		.data_wdata_i  (data_wdata),
		.data_gnt_o    (data_gnt),
		.data_rvalid_o (data_rvalid),
		.data_rdata_o  (data_rdata),
		.pause_req_i   (pause_req),
		.pause_ack_o   (pause_ack)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input string name, input hart_mem_pkg::data_t got,
		input hart_mem_pkg::data_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	function automatic hart_mem_pkg::addr_t word_addr(input hart_mem_pkg::word_idx_t idx);
		return hart_mem_pkg::addr_t'(idx) << 2;
	endfunction

	// Only the enabled byte lanes take the new data
	task automatic model_write(input hart_mem_pkg::word_idx_t idx,
		input hart_mem_pkg::strb_t be, input hart_mem_pkg::data_t wdata);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
	endtask

	task automatic inst_wait_grant();
		@(posedge clk);
		while (inst_gnt !== 1'b1) begin
			@(posedge clk);
		end
		inst_exp_q.push_back(model_mem[inst_idx]);
	endtask

	task automatic data_wait_grant();
		@(posedge clk);
		while (data_gnt !== 1'b1) begin
			@(posedge clk);
		end
		if (data_we) begin
			model_write(data_idx, data_be, data_wdata);
			data_exp_q.push_back('0);
			data_chk_q.push_back(1'b0);
		end
		else begin
			data_exp_q.push_back(model_mem[data_idx]);
			data_chk_q.push_back(1'b1);
		end
	endtask

	task automatic inst_fetch(input hart_mem_pkg::word_idx_t idx);
		@(negedge clk);
		inst_req  = 1'b1;
		inst_idx  = idx;
		inst_addr = word_addr(idx);
		inst_wait_grant();
	endtask

	task automatic data_access(input logic we, input hart_mem_pkg::word_idx_t idx,
		input hart_mem_pkg::strb_t be, input hart_mem_pkg::data_t wdata);
		@(negedge clk);
		data_req   = 1'b1;
		data_we    = we;
		data_idx   = idx;
		data_addr  = word_addr(idx);
		data_be    = be;
		data_wdata = wdata;
		data_wait_grant();
	endtask

	task automatic release_ports();
		@(negedge clk);
		inst_req = 1'b0;
		data_req = 1'b0;
	endtask

	// Wait until every granted request has seen its rvalid
	task automatic drain();
		while (inst_exp_q.size() != 0 || data_exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin : inst_monitor
		forever begin
			@(posedge clk);
			if (inst_rvalid === 1'b1) begin
				if (inst_exp_q.size() == 0) begin
					stop_on_error("inst_rvalid_o pulsed with no fetch outstanding");
				end
				else begin
					check_eq("inst_rdata_o", inst_rdata, inst_exp_q.pop_front());
				end
			end
		end
	end

	initial begin : data_monitor
		hart_mem_pkg::data_t exp_word;
		bit                  chk;
		forever begin
			@(posedge clk);
			if (data_rvalid === 1'b1) begin
				if (data_exp_q.size() == 0) begin
					stop_on_error("data_rvalid_o pulsed with no access outstanding");
				end
				else begin
					exp_word = data_exp_q.pop_front();
					chk      = data_chk_q.pop_front();
					// Write responses carry no defined data
					if (chk) begin
						check_eq("data_rdata_o", data_rdata, exp_word);
					end
				end
			end
		end
	end

	// No grant may slip through while paused
	initial begin : pause_monitor
		forever begin
			@(posedge clk);
			if (pause_ack === 1'b1) begin
				check_eq("inst_gnt_o", hart_mem_pkg::data_t'(inst_gnt), '0);
				check_eq("data_gnt_o", hart_mem_pkg::data_t'(data_gnt), '0);
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		stop_on_error($sformatf("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin : main
		hart_mem_pkg::data_t r;

		void'($urandom(32'h16c5));
		rst_n      = 1'b0;
		inst_req   = 1'b0;
		inst_addr  = '0;
		inst_idx   = '0;
		data_req   = 1'b0;
		data_addr  = '0;
		data_idx   = '0;
		data_we    = 1'b0;
		data_be    = '0;
		data_wdata = '0;
		pause_req  = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		@(posedge clk);
		check_eq("inst_gnt_o", hart_mem_pkg::data_t'(inst_gnt), '0);
		check_eq("data_gnt_o", hart_mem_pkg::data_t'(data_gnt), '0);
		check_eq("inst_rvalid_o", hart_mem_pkg::data_t'(inst_rvalid), '0);
		check_eq("data_rvalid_o", hart_mem_pkg::data_t'(data_rvalid), '0);
		check_eq("pause_ack_o", hart_mem_pkg::data_t'(pause_ack), '0);

		// Fill every word so that all later reads are defined
		for (int i = 0; i < MEM_WORDS; i++) begin
			data_access(1'b1, hart_mem_pkg::word_idx_t'(i), 4'hf, $urandom());
		end

		// Partial writes, then read back
		for (int i = 0; i < N_WR; i++) begin
			r = $urandom();
			wr_idx[i] = hart_mem_pkg::word_idx_t'(r);
			data_access(1'b1, wr_idx[i], hart_mem_pkg::strb_t'(r >> 8), $urandom());
		end
		for (int i = 0; i < N_WR + N_EXTRA; i++) begin
			r = $urandom();
			data_access(1'b0, (i < N_WR) ? wr_idx[i] : hart_mem_pkg::word_idx_t'(r), '0, '0);
		end
		release_ports();
		drain();

		// Fetches see what the data port wrote
		for (int i = 0; i < N_WR + N_EXTRA; i++) begin
			r = $urandom();
			inst_fetch((i < N_WR) ? wr_idx[i] : hart_mem_pkg::word_idx_t'(r));
		end
		release_ports();
		drain();

		// Both ports at once, fetches in the lower half, writes in the upper half
		fork
			begin : inst_stream
				hart_mem_pkg::data_t ri;
				for (int i = 0; i < N_CC; i++) begin
					ri = $urandom();
					inst_fetch(hart_mem_pkg::word_idx_t'(ri % HALF_WORDS));
				end
				@(negedge clk);
				inst_req = 1'b0;
			end
			begin : data_stream
				hart_mem_pkg::data_t rd;
				for (int i = 0; i < N_CC; i++) begin
					rd = $urandom();
					if (rd[31]) begin
						data_access(1'b1, hart_mem_pkg::word_idx_t'(HALF_WORDS + rd % HALF_WORDS),
							hart_mem_pkg::strb_t'(rd >> 16), $urandom());
					end
					else begin
						data_access(1'b0, hart_mem_pkg::word_idx_t'(rd), '0, '0);
					end
				end
				@(negedge clk);
				data_req = 1'b0;
			end
		join
		drain();

		// Pause with one transaction in flight and one held on each port
		r = $urandom();
		fork
			inst_fetch(hart_mem_pkg::word_idx_t'(r % HALF_WORDS));
			data_access(1'b1, hart_mem_pkg::word_idx_t'(HALF_WORDS + r % HALF_WORDS), 4'hf,
				$urandom());
		join
		@(negedge clk);
		pause_req = 1'b1;
		inst_idx  = hart_mem_pkg::word_idx_t'((r >> 8) % HALF_WORDS);
		inst_addr = word_addr(inst_idx);
		data_we   = 1'b0;
		data_be   = '0;
		@(posedge clk);
		while (pause_ack !== 1'b1) begin
			check_eq("inst_gnt_o", hart_mem_pkg::data_t'(inst_gnt), '0);
			check_eq("data_gnt_o", hart_mem_pkg::data_t'(data_gnt), '0);
			@(posedge clk);
		end
		repeat (4) begin
			@(posedge clk);
			check_eq("pause_ack_o", hart_mem_pkg::data_t'(pause_ack), 32'h1);
		end
		@(negedge clk);
		pause_req = 1'b0;
		// Held read targets the word written just before the pause
		fork
			inst_wait_grant();
			data_wait_grant();
		join
		release_ports();
		drain();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- hw/hart_mem_pkg.sv
`include "hart_mem_defines.svh"

package hart_mem_pkg;

	// Byte address from the hart
	typedef logic [`HM_ADDR_WIDTH-1:0] addr_t;

	// Data word on every bus in the subsystem
	typedef logic [`HM_DATA_WIDTH-1:0] data_t;

	// One enable per byte lane
	typedef logic [`HM_DATA_WIDTH/8-1:0] strb_t;

	// Word index into the SRAM bank
	typedef logic [`HM_MEM_WORDS_LOG2-1:0] word_idx_t;

	// Bridge FSM
	// IDLE accepts on OBI, ISSUE waits for the arbiter, RESP waits for data
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		ISSUE = 2'd1,
		RESP  = 2'd2
	} bridge_state_e;

endpackage

//--- hw/hart_mem_port.sv
module hart_mem_port (
	input  logic                clk_i,
	input  logic                rst_n_i,

	input  logic                pause_req_i,
	output logic                pause_ack_o,

	input  logic                inst_req_i,
	input  hart_mem_pkg::addr_t inst_addr_i,
	output logic                inst_gnt_o,
	output logic                inst_rvalid_o,
	output hart_mem_pkg::data_t inst_rdata_o,

	input  logic                data_req_i,
	input  hart_mem_pkg::addr_t data_addr_i,
	input  logic                data_we_i,
	input  hart_mem_pkg::strb_t data_be_i,
	input  hart_mem_pkg::data_t data_wdata_i,
	output logic                data_gnt_o,
	output logic                data_rvalid_o,
	output hart_mem_pkg::data_t data_rdata_o,

	output logic                inst_mem_req_o,
	output hart_mem_pkg::addr_t inst_mem_addr_o,
	output logic                inst_mem_we_o,
	output hart_mem_pkg::strb_t inst_mem_be_o,
	output hart_mem_pkg::data_t inst_mem_wdata_o,
	input  logic                inst_mem_gnt_i,
	input  logic                inst_mem_rvalid_i,
	input  hart_mem_pkg::data_t inst_mem_rdata_i,

	output logic                data_mem_req_o,
	output hart_mem_pkg::addr_t data_mem_addr_o,
	output logic                data_mem_we_o,
	output hart_mem_pkg::strb_t data_mem_be_o,
	output hart_mem_pkg::data_t data_mem_wdata_o,
	input  logic                data_mem_gnt_i,
	input  logic                data_mem_rvalid_i,
	input  hart_mem_pkg::data_t data_mem_rdata_i
);

	logic inst_pause_ack;
	logic data_pause_ack;

	// Fetch side is read only
	obi_mem_bridge inst_bridge (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.pause_req_i  (pause_req_i),
		.pause_ack_o  (inst_pause_ack),
		.req_i        (inst_req_i),
		.addr_i       (inst_addr_i),
		.we_i         (1'b0),
		.be_i         (hart_mem_pkg::strb_t'(0)),
		.wdata_i      (hart_mem_pkg::data_t'(0)),
		.gnt_o        (inst_gnt_o),
		.rvalid_o     (inst_rvalid_o),
		.rdata_o      (inst_rdata_o),
		.mem_req_o    (inst_mem_req_o),
		.mem_addr_o   (inst_mem_addr_o),
		.mem_we_o     (inst_mem_we_o),
		.mem_be_o     (inst_mem_be_o),
		.mem_wdata_o  (inst_mem_wdata_o),
		.mem_gnt_i    (inst_mem_gnt_i),
		.mem_rvalid_i (inst_mem_rvalid_i),
		.mem_rdata_i  (inst_mem_rdata_i)
	);

	obi_mem_bridge data_bridge (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.pause_req_i  (pause_req_i),
		.pause_ack_o  (data_pause_ack),
		.req_i        (data_req_i),
		.addr_i       (data_addr_i),
		.we_i         (data_we_i),
		.be_i         (data_be_i),
		.wdata_i      (data_wdata_i),
		.gnt_o        (data_gnt_o),
		.rvalid_o     (data_rvalid_o),
		.rdata_o      (data_rdata_o),
		.mem_req_o    (data_mem_req_o),
		.mem_addr_o   (data_mem_addr_o),
		.mem_we_o     (data_mem_we_o),
		.mem_be_o     (data_mem_be_o),
		.mem_wdata_o  (data_mem_wdata_o),
		.mem_gnt_i    (data_mem_gnt_i),
		.mem_rvalid_i (data_mem_rvalid_i),
		.mem_rdata_i  (data_mem_rdata_i)
	);

	// Paused only when both bridges are idle
	always_comb begin
		if (pause_req_i) begin
			pause_ack_o = inst_pause_ack && data_pause_ack;
		end
		else begin
			pause_ack_o = inst_pause_ack || data_pause_ack;
		end
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		inst_mem_req_o |-> !inst_mem_we_o)
		else $error("write presented on fetch side");

endmodule

//--- hw/hart_mem_subsys.sv
module hart_mem_subsys (
	input  logic                clk_i,
	input  logic                rst_n_i,

	input  logic                inst_req_i,
	input  hart_mem_pkg::addr_t inst_addr_i,
	output logic                inst_gnt_o,
	output logic                inst_rvalid_o,
	output hart_mem_pkg::data_t inst_rdata_o,

	input  logic                data_req_i,
	input  hart_mem_pkg::addr_t data_addr_i,
	input  logic                data_we_i,
	input  hart_mem_pkg::strb_t data_be_i,
	input  hart_mem_pkg::data_t data_wdata_i,
	output logic                data_gnt_o,
	output logic                data_rvalid_o,
	output hart_mem_pkg::data_t data_rdata_o,

	input  logic                pause_req_i,
	output logic                pause_ack_o
);

	logic                inst_mem_req;
	hart_mem_pkg::addr_t inst_mem_addr;
	logic                inst_mem_we;
	hart_mem_pkg::strb_t inst_mem_be;
	hart_mem_pkg::data_t inst_mem_wdata;
	logic                inst_mem_gnt;
	logic                inst_mem_rvalid;
	hart_mem_pkg::data_t inst_mem_rdata;

	logic                data_mem_req;
	hart_mem_pkg::addr_t data_mem_addr;
	logic                data_mem_we;
	hart_mem_pkg::strb_t data_mem_be;
	hart_mem_pkg::data_t data_mem_wdata;
	logic                data_mem_gnt;
	logic                data_mem_rvalid;
	hart_mem_pkg::data_t data_mem_rdata;

	logic                    sram_en;
	logic                    sram_we;
	hart_mem_pkg::strb_t     sram_be;
	hart_mem_pkg::word_idx_t sram_idx;
	hart_mem_pkg::data_t     sram_wdata;
	hart_mem_pkg::data_t     sram_rdata;

	hart_mem_port u_port (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.pause_req_i       (pause_req_i),
		.pause_ack_o       (pause_ack_o),
		.inst_req_i        (inst_req_i),
		.inst_addr_i       (inst_addr_i),
		.inst_gnt_o        (inst_gnt_o),
		.inst_rvalid_o     (inst_rvalid_o),
		.inst_rdata_o      (inst_rdata_o),
		.data_req_i        (data_req_i),
		.data_addr_i       (data_addr_i),
		.data_we_i         (data_we_i),
		.data_be_i         (data_be_i),
		.data_wdata_i      (data_wdata_i),
		.data_gnt_o        (data_gnt_o),
		.data_rvalid_o     (data_rvalid_o),
		.data_rdata_o      (data_rdata_o),
		.inst_mem_req_o    (inst_mem_req),
		.inst_mem_addr_o   (inst_mem_addr),
		.inst_mem_we_o     (inst_mem_we),
		.inst_mem_be_o     (inst_mem_be),
		.inst_mem_wdata_o  (inst_mem_wdata),
		.inst_mem_gnt_i    (inst_mem_gnt),
		.inst_mem_rvalid_i (inst_mem_rvalid),
		.inst_mem_rdata_i  (inst_mem_rdata),
		.data_mem_req_o    (data_mem_req),
		.data_mem_addr_o   (data_mem_addr),
		.data_mem_we_o     (data_mem_we),
		.data_mem_be_o     (data_mem_be),
		.data_mem_wdata_o  (data_mem_wdata),
		.data_mem_gnt_i    (data_mem_gnt),
		.data_mem_rvalid_i (data_mem_rvalid),
		.data_mem_rdata_i  (data_mem_rdata)
	);

	// Side a is fetch, so it holds priority out of reset
	mem_arbiter u_arbiter (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.a_req_i      (inst_mem_req),
		.a_addr_i     (inst_mem_addr),
		.a_we_i       (inst_mem_we),
		.a_be_i       (inst_mem_be),
		.a_wdata_i    (inst_mem_wdata),
		.a_gnt_o      (inst_mem_gnt),
		.a_rvalid_o   (inst_mem_rvalid),
		.a_rdata_o    (inst_mem_rdata),
		.b_req_i      (data_mem_req),
		.b_addr_i     (data_mem_addr),
		.b_we_i       (data_mem_we),
		.b_be_i       (data_mem_be),
		.b_wdata_i    (data_mem_wdata),
		.b_gnt_o      (data_mem_gnt),
		.b_rvalid_o   (data_mem_rvalid),
		.b_rdata_o    (data_mem_rdata),
		.sram_en_o    (sram_en),
		.sram_we_o    (sram_we),
		.sram_be_o    (sram_be),
		.sram_idx_o   (sram_idx),
		.sram_wdata_o (sram_wdata),
		.sram_rdata_i (sram_rdata)
	);

	sram_bank u_sram (
		.clk_i   (clk_i),
		.en_i    (sram_en),
		.we_i    (sram_we),
		.be_i    (sram_be),
		.idx_i   (sram_idx),
		.wdata_i (sram_wdata),
		.rdata_o (sram_rdata)
	);

endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter (
	input  logic                      clk_i,
	input  logic                      rst_n_i,

	input  logic                      a_req_i,
	input  hart_mem_pkg::addr_t       a_addr_i,
	input  logic                      a_we_i,
	input  hart_mem_pkg::strb_t       a_be_i,
	input  hart_mem_pkg::data_t       a_wdata_i,
	output logic                      a_gnt_o,
	output logic                      a_rvalid_o,
	output hart_mem_pkg::data_t       a_rdata_o,

	input  logic                      b_req_i,
	input  hart_mem_pkg::addr_t       b_addr_i,
	input  logic                      b_we_i,
	input  hart_mem_pkg::strb_t       b_be_i,
	input  hart_mem_pkg::data_t       b_wdata_i,
	output logic                      b_gnt_o,
	output logic                      b_rvalid_o,
	output hart_mem_pkg::data_t       b_rdata_o,

	output logic                      sram_en_o,
	output logic                      sram_we_o,
	output hart_mem_pkg::strb_t       sram_be_o,
	output hart_mem_pkg::word_idx_t   sram_idx_o,
	output hart_mem_pkg::data_t       sram_wdata_o,
	input  hart_mem_pkg::data_t       sram_rdata_i
);

	// Set when side b should win a tie
	logic prio_b_q;
	logic resp_q;
	logic resp_b_q;

	hart_mem_pkg::addr_t sel_addr;

	assign a_gnt_o = a_req_i && (!b_req_i || !prio_b_q);
	assign b_gnt_o = b_req_i && (!a_req_i || prio_b_q);

	assign sram_en_o    = a_gnt_o || b_gnt_o;
	assign sram_we_o    = b_gnt_o ? b_we_i    : a_we_i;
	assign sram_be_o    = b_gnt_o ? b_be_i    : a_be_i;
	assign sram_wdata_o = b_gnt_o ? b_wdata_i : a_wdata_i;
	assign sel_addr     = b_gnt_o ? b_addr_i  : a_addr_i;

	// Drop the byte offset, upper bits beyond the bank are ignored
	assign sram_idx_o = hart_mem_pkg::word_idx_t'(sel_addr >> 2);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			prio_b_q <= 1'b0;
			resp_q   <= 1'b0;
			resp_b_q <= 1'b0;
		end
		else begin
			resp_q   <= sram_en_o;
			resp_b_q <= b_gnt_o;
			if (sram_en_o) begin
				prio_b_q <= a_gnt_o;
			end
		end
	end

	// Read data goes to both sides, rvalid picks the owner
	assign a_rvalid_o = resp_q && !resp_b_q;
	assign b_rvalid_o = resp_q && resp_b_q;
	assign a_rdata_o  = sram_rdata_i;
	assign b_rdata_o  = sram_rdata_i;

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(a_gnt_o && b_gnt_o))
		else $error("both sides granted");

endmodule

//--- hw/obi_mem_bridge.sv
module obi_mem_bridge (
	input  logic                clk_i,
	input  logic                rst_n_i,

	input  logic                pause_req_i,
	output logic                pause_ack_o,

	input  logic                req_i,
	input  hart_mem_pkg::addr_t addr_i,
	input  logic                we_i,
	input  hart_mem_pkg::strb_t be_i,
	input  hart_mem_pkg::data_t wdata_i,
	output logic                gnt_o,
	output logic                rvalid_o,
	output hart_mem_pkg::data_t rdata_o,

	output logic                mem_req_o,
	output hart_mem_pkg::addr_t mem_addr_o,
	output logic                mem_we_o,
	output hart_mem_pkg::strb_t mem_be_o,
	output hart_mem_pkg::data_t mem_wdata_o,
	input  logic                mem_gnt_i,
	input  logic                mem_rvalid_i,
	input  hart_mem_pkg::data_t mem_rdata_i
);

	hart_mem_pkg::bridge_state_e state_q;
	hart_mem_pkg::bridge_state_e state_d;

	hart_mem_pkg::addr_t addr_q;
	logic                we_q;
	hart_mem_pkg::strb_t be_q;
	hart_mem_pkg::data_t wdata_q;
	hart_mem_pkg::data_t rdata_q;
	logic                rvalid_q;

	// Only one transaction in flight, and pause holds off new ones
	assign gnt_o       = (state_q == hart_mem_pkg::IDLE) && req_i && !pause_req_i;
	assign pause_ack_o = pause_req_i && (state_q == hart_mem_pkg::IDLE);

	assign mem_req_o   = (state_q == hart_mem_pkg::ISSUE);
	assign mem_addr_o  = addr_q;
	assign mem_we_o    = we_q;
	assign mem_be_o    = be_q;
	assign mem_wdata_o = wdata_q;

	assign rvalid_o = rvalid_q;
	assign rdata_o  = rdata_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			hart_mem_pkg::IDLE: begin
				if (gnt_o) begin
					state_d = hart_mem_pkg::ISSUE;
				end
			end
			hart_mem_pkg::ISSUE: begin
				if (mem_gnt_i) begin
					state_d = hart_mem_pkg::RESP;
				end
			end
			hart_mem_pkg::RESP: begin
				// Leave once the OBI response pulse has gone out
				if (rvalid_q) begin
					state_d = hart_mem_pkg::IDLE;
				end
			end
			default: begin
				state_d = hart_mem_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= hart_mem_pkg::IDLE;
			rvalid_q <= 1'b0;
		end
		else begin
			state_q  <= state_d;
			rvalid_q <= (state_q == hart_mem_pkg::RESP) && mem_rvalid_i;
		end
	end

	// Request payload, captured on the OBI grant
	always_ff @(posedge clk_i) begin
		if (gnt_o) begin
			addr_q  <= addr_i;
			we_q    <= we_i;
			be_q    <= be_i;
			wdata_q <= wdata_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if ((state_q == hart_mem_pkg::RESP) && mem_rvalid_i) begin
			rdata_q <= mem_rdata_i;
		end
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o) &&
			$stable(mem_we_o) && $stable(mem_be_o) && $stable(mem_wdata_o)))
		else $error("mem request changed before grant");

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rvalid_o |-> (state_q != hart_mem_pkg::IDLE))
		else $error("rvalid raised while bridge idle");

endmodule

//--- hw/sram_bank.sv
`include "hart_mem_defines.svh"

module sram_bank (
	input  logic                    clk_i,

	input  logic                    en_i,
	input  logic                    we_i,
	input  hart_mem_pkg::strb_t     be_i,
	input  hart_mem_pkg::word_idx_t idx_i,
	input  hart_mem_pkg::data_t     wdata_i,
	output hart_mem_pkg::data_t     rdata_o
);

	localparam int unsigned DEPTH = 1 << `HM_MEM_WORDS_LOG2;
	localparam int unsigned LANES = `HM_DATA_WIDTH / 8;

	hart_mem_pkg::data_t mem_q [DEPTH];

	// Byte lane writes
	always_ff @(posedge clk_i) begin
		if (en_i && we_i) begin
			for (int i = 0; i < LANES; i++) begin
				if (be_i[i]) begin
					mem_q[idx_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
				end
			end
		end
	end

	// Read-first, a write cycle returns the previous word
	always_ff @(posedge clk_i) begin
		if (en_i) begin
			rdata_o <= mem_q[idx_i];
		end
	end

endmodule

//--- include/hart_mem_defines.svh
`ifndef HART_MEM_DEFINES_SVH
`define HART_MEM_DEFINES_SVH

// Byte address width seen on both OBI ports
`define HM_ADDR_WIDTH 32

// Data bus width, one word per transfer
`define HM_DATA_WIDTH 32

// SRAM depth in words, as a power of two
// 8 gives a 256 word bank, 1 KiB
`define HM_MEM_WORDS_LOG2 8

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the hart memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_hart_mem_subsys -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi

exit 0

//--- sources.f
+incdir+include
hw/hart_mem_pkg.sv
hw/obi_mem_bridge.sv
hw/mem_arbiter.sv
hw/sram_bank.sv
hw/hart_mem_port.sv
hw/hart_mem_subsys.sv
dv/tb_clk_gen.sv
dv/tb_hart_mem_subsys.sv
